// ==== logic/vidctl_pkg.sv ====
package vidctl_pkg;

    // frame geometry, one pixel per memory word
    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 4;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

    localparam int NUM_BUFFERS   = 3;
    localparam int BUF_IDX_W     = 2;
    // guard gap of 32 words between buffers
    localparam int BUFFER_STRIDE = FRAME_PIXELS + 32;

    localparam int ADDR_W      = 21;
    localparam int DATA_W      = 32;
    localparam int LOAD_ADDR_W = 10;
    localparam int STORE_W     = 17;

    localparam logic [7:0] MEM_INIT_DELAY = 8'd152;

    typedef enum logic [2:0] {
        BUF_AVAILABLE,
        BUF_WRITE_BUSY,
        BUF_READ_BUSY,
        BUF_DISPLAYED,
        BUF_UPDATED
    } buf_state_e;

    typedef enum logic {
        META_ACQUIRE,
        META_RELEASE
    } meta_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START_WAIT,
        S_LOCK,
        S_START,
        S_RUN,
        S_RELEASE_LOCK
    } session_state_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_cmd_e;

endpackage

// ==== logic/buffer_table.sv ====
`timescale 1ns/1ps

module buffer_table (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          up_lock_req_i,
    input  vidctl_pkg::meta_op_e          up_op_i,
    input  logic                          dn_lock_req_i,
    input  vidctl_pkg::meta_op_e          dn_op_i,
    output logic                          up_lock_grant_o,
    output logic                          dn_lock_grant_o,
    output logic [vidctl_pkg::ADDR_W-1:0] write_base_o,
    output logic [vidctl_pkg::ADDR_W-1:0] read_base_o
);
    import vidctl_pkg::*;

    buf_state_e           buf_state [NUM_BUFFERS];
    logic [BUF_IDX_W-1:0] up_idx;
    logic [BUF_IDX_W-1:0] dn_idx;
    logic [BUF_IDX_W-1:0] up_pick;
    logic [BUF_IDX_W-1:0] dn_pick;
    logic                 up_served_last;

    // classes tried in order, lowest index wins inside a class
    function automatic logic [BUF_IDX_W-1:0] pick_buffer(
        input buf_state_e first_st,
        input buf_state_e last_st,
        input buf_state_e states [NUM_BUFFERS]
    );
        buf_state_e           prio [3];
        logic [BUF_IDX_W-1:0] idx;

        prio[0] = first_st;
        prio[1] = BUF_AVAILABLE;
        prio[2] = last_st;
        idx = '0;
        for (int p = 2; p >= 0; p--) begin
            for (int i = NUM_BUFFERS - 1; i >= 0; i--) begin
                if (states[i] == prio[p]) begin
                    idx = BUF_IDX_W'(i);
                end
            end
        end
        return idx;
    endfunction

    assign up_pick = pick_buffer(BUF_DISPLAYED, BUF_UPDATED, buf_state);
    assign dn_pick = pick_buffer(BUF_UPDATED, BUF_DISPLAYED, buf_state);

    // one grant per cycle, alternate on a tie
    assign up_lock_grant_o = up_lock_req_i && (!dn_lock_req_i || !up_served_last);
    assign dn_lock_grant_o = dn_lock_req_i && !up_lock_grant_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                buf_state[i] <= BUF_AVAILABLE;
            end
            up_idx         <= '0;
            dn_idx         <= '0;
            write_base_o   <= '0;
            read_base_o    <= '0;
            up_served_last <= 1'b0;
        end else if (up_lock_grant_o) begin
            up_served_last <= 1'b1;
            if (up_op_i == META_ACQUIRE) begin
                buf_state[up_pick] <= BUF_WRITE_BUSY;
                up_idx             <= up_pick;
                write_base_o       <= ADDR_W'(up_pick) * ADDR_W'(BUFFER_STRIDE);
            end else begin
                buf_state[up_idx] <= BUF_UPDATED;
            end
        end else if (dn_lock_grant_o) begin
            up_served_last <= 1'b0;
            if (dn_op_i == META_ACQUIRE) begin
                buf_state[dn_pick] <= BUF_READ_BUSY;
                dn_idx             <= dn_pick;
                read_base_o        <= ADDR_W'(dn_pick) * ADDR_W'(BUFFER_STRIDE);
            end else begin
                buf_state[dn_idx] <= BUF_DISPLAYED;
            end
        end
    end

endmodule

// ==== logic/frame_session.sv ====
`timescale 1ns/1ps

module frame_session (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 startup_done_i,
    input  logic                 lock_grant_i,
    input  logic                 done_i,
    output logic                 lock_req_o,
    output vidctl_pkg::meta_op_e op_o,
    output logic                 start_o
);
    import vidctl_pkg::*;

    session_state_e state;
    session_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                state_next = S_START_WAIT;
            end
            S_START_WAIT: begin
                if (startup_done_i) begin
                    state_next = S_LOCK;
                end
            end
            S_LOCK: begin
                if (lock_grant_i) begin
                    state_next = S_START;
                end
            end
            S_START: begin
                state_next = S_RUN;
            end
            S_RUN: begin
                if (done_i) begin
                    state_next = S_RELEASE_LOCK;
                end
            end
            S_RELEASE_LOCK: begin
                if (lock_grant_i) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // request held in both lock states, op tells them apart
    assign lock_req_o = (state == S_LOCK) || (state == S_RELEASE_LOCK);
    assign op_o       = (state == S_RELEASE_LOCK) ? META_RELEASE : META_ACQUIRE;
    assign start_o    = (state == S_START);

endmodule

// ==== logic/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start_i,
    input  logic [vidctl_pkg::ADDR_W-1:0]      base_i,
    input  logic                               load_valid_i,
    input  logic [vidctl_pkg::DATA_W-1:0]      load_pixel_i,
    input  logic                               wr_grant_i,
    output logic                               load_rd_o,
    output logic [vidctl_pkg::LOAD_ADDR_W-1:0] load_addr_o,
    output logic                               wr_req_o,
    output logic [vidctl_pkg::ADDR_W-1:0]      wr_addr_o,
    output logic [vidctl_pkg::DATA_W-1:0]      wr_data_o,
    output logic                               done_o
);
    import vidctl_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_FETCH,
        W_WAIT,
        W_WRITE
    } writer_state_e;

    writer_state_e                     state;
    logic [$clog2(FRAME_PIXELS)-1:0] pix_cnt;
    logic                              pix_last;

    assign pix_last = (pix_cnt == FRAME_PIXELS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= W_IDLE;
            pix_cnt <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (start_i) begin
                        pix_cnt <= '0;
                        state   <= W_FETCH;
                    end
                end
                W_FETCH: begin
                    state <= W_WAIT;
                end
                W_WAIT: begin
                    if (load_valid_i) begin
                        state <= W_WRITE;
                    end
                end
                W_WRITE: begin
                    if (wr_grant_i) begin
                        if (pix_last) begin
                            done_o <= 1'b1;
                            state  <= W_IDLE;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                            state   <= W_FETCH;
                        end
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    // pixel held until the write is granted
    always_ff @(posedge clk) begin
        if (state == W_WAIT && load_valid_i) begin
            wr_data_o <= load_pixel_i;
        end
    end

    assign load_rd_o   = (state == W_FETCH);
    assign load_addr_o = LOAD_ADDR_W'(pix_cnt);
    assign wr_req_o    = (state == W_WRITE);
    assign wr_addr_o   = base_i + ADDR_W'(pix_cnt);

endmodule

// ==== logic/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [vidctl_pkg::ADDR_W-1:0]  base_i,
    input  logic                           rd_grant_i,
    input  logic                           rd_data_valid_i,
    input  logic [vidctl_pkg::DATA_W-1:0]  rd_data_i,
    input  logic                           store_full_i,
    output logic                           rd_req_o,
    output logic [vidctl_pkg::ADDR_W-1:0]  rd_addr_o,
    output logic                           store_wr_en_o,
    output logic [vidctl_pkg::STORE_W-1:0] store_data_o,
    output logic                           done_o
);
    import vidctl_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_WAIT,
        R_PUSH
    } reader_state_e;

    reader_state_e                     state;
    logic [$clog2(FRAME_PIXELS)-1:0] pix_cnt;
    logic                              pix_last;
    logic [DATA_W-1:0]                 rd_word;

    assign pix_last = (pix_cnt == FRAME_PIXELS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= R_IDLE;
            pix_cnt <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (start_i) begin
                        pix_cnt <= '0;
                        state   <= R_REQ;
                    end
                end
                R_REQ: begin
                    if (rd_grant_i) begin
                        state <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (rd_data_valid_i) begin
                        state <= R_PUSH;
                    end
                end
                R_PUSH: begin
                    if (!store_full_i) begin
                        if (pix_last) begin
                            done_o <= 1'b1;
                            state  <= R_IDLE;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                            state   <= R_REQ;
                        end
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_WAIT && rd_data_valid_i) begin
            rd_word <= rd_data_i;
        end
    end

    // no new read while the queue is full
    assign rd_req_o      = (state == R_REQ) && !store_full_i;
    assign rd_addr_o     = base_i + ADDR_W'(pix_cnt);
    assign store_wr_en_o = (state == R_PUSH) && !store_full_i;
    // bit 16 flags the last pixel of the frame
    assign store_data_o  = {pix_last, rd_word[STORE_W-2:0]};

endmodule

// ==== logic/mem_port_arbiter.sv ====
`timescale 1ns/1ps

module mem_port_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_req_i,
    input  logic [vidctl_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [vidctl_pkg::DATA_W-1:0] wr_data_i,
    input  logic                          rd_req_i,
    input  logic [vidctl_pkg::ADDR_W-1:0] rd_addr_i,
    output logic                          wr_grant_o,
    output logic                          rd_grant_o,
    output logic                          cmd_en_o,
    output vidctl_pkg::mem_cmd_e          cmd_o,
    output logic [vidctl_pkg::ADDR_W-1:0] addr_o,
    output logic [vidctl_pkg::DATA_W-1:0] wr_data_o
);
    import vidctl_pkg::*;

    logic wr_served_last;

    // writer wins unless it was served last and the reader waits
    assign wr_grant_o = wr_req_i && (!rd_req_i || !wr_served_last);
    assign rd_grant_o = rd_req_i && !wr_grant_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_served_last <= 1'b0;
        end else if (wr_grant_o) begin
            wr_served_last <= 1'b1;
        end else if (rd_grant_o) begin
            wr_served_last <= 1'b0;
        end
    end

    assign cmd_en_o  = wr_grant_o || rd_grant_o;
    assign cmd_o     = wr_grant_o ? MEM_WRITE : MEM_READ;
    assign addr_o    = wr_grant_o ? wr_addr_i : (rd_grant_o ? rd_addr_i : '0);
    assign wr_data_o = wr_grant_o ? wr_data_i : '0;

endmodule

// ==== logic/video_controller.sv ====
`timescale 1ns/1ps

module video_controller (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               init_done_i,
    input  logic [vidctl_pkg::DATA_W-1:0]      rd_data_i,
    input  logic                               rd_data_valid_i,
    input  logic                               load_valid_i,
    input  logic [vidctl_pkg::DATA_W-1:0]      load_pixel_i,
    input  logic                               store_full_i,
    output logic [vidctl_pkg::ADDR_W-1:0]      addr_o,
    output vidctl_pkg::mem_cmd_e               cmd_o,
    output logic                               cmd_en_o,
    output logic [vidctl_pkg::DATA_W-1:0]      wr_data_o,
    output logic                               load_rd_o,
    output logic [vidctl_pkg::LOAD_ADDR_W-1:0] load_addr_o,
    output logic                               store_wr_en_o,
    output logic [vidctl_pkg::STORE_W-1:0]     store_data_o
);
    import vidctl_pkg::*;

    logic [7:0]        init_cnt;
    logic              startup_done;
    logic              up_lock_req;
    logic              dn_lock_req;
    meta_op_e          up_op;
    meta_op_e          dn_op;
    logic              up_lock_grant;
    logic              dn_lock_grant;
    logic [ADDR_W-1:0] write_base;
    logic [ADDR_W-1:0] read_base;
    logic              up_start;
    logic              dn_start;
    logic              up_done;
    logic              dn_done;
    logic              wr_req;
    logic              wr_grant;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              rd_req;
    logic              rd_grant;
    logic [ADDR_W-1:0] rd_addr;

    // counts init_done cycles, saturates
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_cnt <= '0;
        end else if (init_done_i && init_cnt != MEM_INIT_DELAY) begin
            init_cnt <= init_cnt + 8'd1;
        end
    end

    assign startup_done = (init_cnt == MEM_INIT_DELAY);

    buffer_table buffer_table_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .up_lock_req_i   (up_lock_req),
        .up_op_i         (up_op),
        .dn_lock_req_i   (dn_lock_req),
        .dn_op_i         (dn_op),
        .up_lock_grant_o (up_lock_grant),
        .dn_lock_grant_o (dn_lock_grant),
        .write_base_o    (write_base),
        .read_base_o     (read_base)
    );

    frame_session upload_session (
        .clk            (clk),
        .rst_n          (rst_n),
        .startup_done_i (startup_done),
        .lock_grant_i   (up_lock_grant),
        .done_i         (up_done),
        .lock_req_o     (up_lock_req),
        .op_o           (up_op),
        .start_o        (up_start)
    );

    frame_session download_session (
        .clk            (clk),
        .rst_n          (rst_n),
        .startup_done_i (startup_done),
        .lock_grant_i   (dn_lock_grant),
        .done_i         (dn_done),
        .lock_req_o     (dn_lock_req),
        .op_o           (dn_op),
        .start_o        (dn_start)
    );

    frame_writer frame_writer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (up_start),
        .base_i       (write_base),
        .load_valid_i (load_valid_i),
        .load_pixel_i (load_pixel_i),
        .wr_grant_i   (wr_grant),
        .load_rd_o    (load_rd_o),
        .load_addr_o  (load_addr_o),
        .wr_req_o     (wr_req),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .done_o       (up_done)
    );

    frame_reader frame_reader_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (dn_start),
        .base_i          (read_base),
        .rd_grant_i      (rd_grant),
        .rd_data_valid_i (rd_data_valid_i),
        .rd_data_i       (rd_data_i),
        .store_full_i    (store_full_i),
        .rd_req_o        (rd_req),
        .rd_addr_o       (rd_addr),
        .store_wr_en_o   (store_wr_en_o),
        .store_data_o    (store_data_o),
        .done_o          (dn_done)
    );

    mem_port_arbiter mem_port_arbiter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_req_i   (wr_req),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .rd_req_i   (rd_req),
        .rd_addr_i  (rd_addr),
        .wr_grant_o (wr_grant),
        .rd_grant_o (rd_grant),
        .cmd_en_o   (cmd_en_o),
        .cmd_o      (cmd_o),
        .addr_o     (addr_o),
        .wr_data_o  (wr_data_o)
    );

endmodule

// ==== tb/frame_memory_model.sv ====
`timescale 1ns/1ps

module frame_memory_model (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cmd_en_i,
    input  vidctl_pkg::mem_cmd_e               cmd_i,
    input  logic [vidctl_pkg::ADDR_W-1:0]      addr_i,
    input  logic [vidctl_pkg::DATA_W-1:0]      wr_data_i,
    input  logic                               load_rd_i,
    input  logic [vidctl_pkg::LOAD_ADDR_W-1:0] load_addr_i,
    output logic [vidctl_pkg::DATA_W-1:0]      rd_data_o,
    output logic                               rd_data_valid_o,
    output logic                               load_valid_o,
    output logic [vidctl_pkg::DATA_W-1:0]      load_pixel_o
);
    import vidctl_pkg::*;

    localparam int MEM_WORDS  = 512;
    localparam int RD_LATENCY = 3;

    logic [DATA_W-1:0]     mem [MEM_WORDS];
    logic [DATA_W-1:0]     rd_pipe [RD_LATENCY];
    logic [RD_LATENCY-1:0] vld_pipe;
    int                    load_frame;

    // every word differs, unwritten buffers still read back distinct data
    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = 32'hf00d_0000 ^ (a * 32'h0000_9e37);
        end
    end

    always @(posedge clk) begin
        if (cmd_en_i && cmd_i == MEM_WRITE) begin
            mem[addr_i[8:0]] <= wr_data_i;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe     <= '0;
            load_valid_o <= 1'b0;
            load_pixel_o <= '0;
            load_frame   <= 0;
            for (int i = 0; i < RD_LATENCY; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            vld_pipe   <= {vld_pipe[RD_LATENCY-2:0], cmd_en_i && cmd_i == MEM_READ};
            rd_pipe[0] <= mem[addr_i[8:0]];
            for (int i = 1; i < RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
            // load source answers one cycle after the fetch
            load_valid_o <= load_rd_i;
            if (load_rd_i) begin
                load_pixel_o <= DATA_W'(load_frame * 256) + DATA_W'(load_addr_i);
                if (load_addr_i == FRAME_PIXELS - 1) begin
                    load_frame <= load_frame + 1;
                end
            end
        end
    end

    assign rd_data_valid_o = vld_pipe[RD_LATENCY-1];
    assign rd_data_o       = rd_pipe[RD_LATENCY-1];

endmodule

// ==== tb/video_controller_tb.sv ====
`timescale 1ns/1ps

module video_controller_tb;
    import vidctl_pkg::*;

    localparam int RUN_FRAMES     = 6;
    localparam int TIMEOUT_CYCLES = int'(MEM_INIT_DELAY) * 4 + 8 * FRAME_PIXELS * 16;

    logic                   clk;
    logic                   rst_n;
    logic                   init_done_i;
    logic                   store_full_i;
    logic [DATA_W-1:0]      rd_data;
    logic                   rd_data_valid;
    logic                   load_valid;
    logic [DATA_W-1:0]      load_pixel;
    logic [ADDR_W-1:0]      addr_o;
    mem_cmd_e               cmd_o;
    logic                   cmd_en_o;
    logic [DATA_W-1:0]      wr_data_o;
    logic                   load_rd_o;
    logic [LOAD_ADDR_W-1:0] load_addr_o;
    logic                   store_wr_en_o;
    logic [STORE_W-1:0]     store_data_o;

    integer seed = 32'h5e17_a1b4;

    // tb view of the buffer table
    buf_state_e         buf_st [NUM_BUFFERS];
    int                 up_buf = 0;
    int                 dn_buf = 0;
    bit                 up_busy = 1'b0;
    bit                 dn_busy = 1'b0;
    int                 wr_off = 0;
    int                 rd_off = 0;
    int                 push_cnt = 0;
    int                 up_frames = 0;
    int                 dn_frames = 0;
    int                 up_mark = 0;
    int                 dn_mark = 0;
    int                 init_seen = 0;
    bit                 first_cmd_seen = 1'b0;
    bit                 last_cmd_write = 1'b0;
    int                 cycle_cnt = 0;
    int                 err_cnt = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    bit                 timed_out = 1'b0;
    int                 exp_addr;
    logic [DATA_W-1:0]  mem_word;
    logic [STORE_W-1:0] exp_word;
    logic [STORE_W-1:0] exp_store [$];

    video_controller dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .init_done_i     (init_done_i),
        .rd_data_i       (rd_data),
        .rd_data_valid_i (rd_data_valid),
        .load_valid_i    (load_valid),
        .load_pixel_i    (load_pixel),
        .store_full_i    (store_full_i),
        .addr_o          (addr_o),
        .cmd_o           (cmd_o),
        .cmd_en_o        (cmd_en_o),
        .wr_data_o       (wr_data_o),
        .load_rd_o       (load_rd_o),
        .load_addr_o     (load_addr_o),
        .store_wr_en_o   (store_wr_en_o),
        .store_data_o    (store_data_o)
    );

    frame_memory_model mem_model_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_en_i        (cmd_en_o),
        .cmd_i           (cmd_o),
        .addr_i          (addr_o),
        .wr_data_i       (wr_data_o),
        .load_rd_i       (load_rd_o),
        .load_addr_i     (load_addr_o),
        .rd_data_o       (rd_data),
        .rd_data_valid_o (rd_data_valid),
        .load_valid_o    (load_valid),
        .load_pixel_o    (load_pixel)
    );

    always #2 clk = ~clk;

    // expected buffer for a role, -1 when nothing fits
    function automatic int ref_pick(input bit upload);
        buf_state_e order [3];

        order[0] = upload ? BUF_DISPLAYED : BUF_UPDATED;
        order[1] = BUF_AVAILABLE;
        order[2] = upload ? BUF_UPDATED : BUF_DISPLAYED;
        for (int p = 0; p < 3; p++) begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                if (buf_st[i] == order[p]) begin
                    return i;
                end
            end
        end
        return -1;
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        if (err_cnt == err_mark) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_cnt - err_mark);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            init_done_i  <= ($random(seed) % 4) != 0;
            store_full_i <= ($random(seed) % 4) == 0;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            cycle_cnt++;

            if (cmd_en_o && !first_cmd_seen) begin
                first_cmd_seen = 1'b1;
                if (init_seen < MEM_INIT_DELAY) begin
                    report_error($sformatf("command after only %0d init cycles", init_seen));
                end
                finish_test("startup delay", 0);
            end
            if (init_done_i && init_seen < MEM_INIT_DELAY) begin
                init_seen++;
            end

            if (dut_i.up_lock_grant) begin
                if (dut_i.up_op == META_ACQUIRE) begin
                    up_buf = ref_pick(1'b1);
                    if (up_buf < 0) begin
                        report_error("reference found no buffer for upload");
                        up_buf = 0;
                    end
                    buf_st[up_buf] = BUF_WRITE_BUSY;
                    up_busy = 1'b1;
                    wr_off  = 0;
                    up_mark = err_cnt;
                end else begin
                    if (wr_off != FRAME_PIXELS) begin
                        report_error($sformatf("upload released after %0d writes", wr_off));
                    end
                    buf_st[up_buf] = BUF_UPDATED;
                    up_busy = 1'b0;
                    finish_test($sformatf("upload frame %0d into buffer %0d", up_frames, up_buf),
                                up_mark);
                    up_frames++;
                end
            end

            if (dut_i.dn_lock_grant) begin
                if (dut_i.dn_op == META_ACQUIRE) begin
                    dn_buf = ref_pick(1'b0);
                    if (dn_buf < 0) begin
                        report_error("reference found no buffer for download");
                        dn_buf = 0;
                    end
                    buf_st[dn_buf] = BUF_READ_BUSY;
                    dn_busy  = 1'b1;
                    rd_off   = 0;
                    push_cnt = 0;
                    dn_mark  = err_cnt;
                end else begin
                    if (rd_off != FRAME_PIXELS || push_cnt != FRAME_PIXELS) begin
                        report_error($sformatf("download released after %0d reads, %0d pushes",
                                               rd_off, push_cnt));
                    end
                    if (exp_store.size() != 0) begin
                        report_error("read data never reached the store queue");
                        exp_store.delete();
                    end
                    buf_st[dn_buf] = BUF_DISPLAYED;
                    dn_busy = 1'b0;
                    finish_test($sformatf("download frame %0d from buffer %0d", dn_frames, dn_buf),
                                dn_mark);
                    dn_frames++;
                end
            end

            // next fetch is for the pixel after the last write
            if (load_rd_o) begin
                if (!up_busy) begin
                    report_error("load fetch with no upload frame open");
                end else if (load_addr_o != LOAD_ADDR_W'(wr_off)) begin
                    report_error($sformatf("load addr %0h, expected %0h", load_addr_o, wr_off));
                end
            end

            if (cmd_en_o && cmd_o == MEM_WRITE) begin
                exp_addr = up_buf * BUFFER_STRIDE + wr_off;
                if (!up_busy) begin
                    report_error("memory write with no upload frame open");
                end else if (addr_o != ADDR_W'(exp_addr)) begin
                    report_error($sformatf("write addr %0h, expected %0h", addr_o, exp_addr));
                end else if (wr_data_o != DATA_W'(up_frames * 256 + wr_off)) begin
                    report_error($sformatf("write data %0h at %0h, expected %0h",
                                           wr_data_o, addr_o, up_frames * 256 + wr_off));
                end
                wr_off++;
            end else if (cmd_en_o) begin
                exp_addr = dn_buf * BUFFER_STRIDE + rd_off;
                if (!dn_busy) begin
                    report_error("memory read with no download frame open");
                end else if (addr_o != ADDR_W'(exp_addr)) begin
                    report_error($sformatf("read addr %0h, expected %0h", addr_o, exp_addr));
                end
                if (up_busy && addr_o >= up_buf * BUFFER_STRIDE
                        && addr_o < up_buf * BUFFER_STRIDE + FRAME_PIXELS) begin
                    report_error($sformatf("read at %0h inside the buffer being written", addr_o));
                end
                mem_word = mem_model_i.mem[addr_o[8:0]];
                exp_word = {(rd_off == FRAME_PIXELS - 1), mem_word[15:0]};
                exp_store.push_back(exp_word);
                rd_off++;
            end

            // on a tie the engine served less recently gets the port
            if (dut_i.wr_req && dut_i.rd_req) begin
                if (!cmd_en_o || ((cmd_o == MEM_WRITE) == last_cmd_write)) begin
                    report_error("memory port tie not given to the engine waiting longer");
                end
            end
            if (cmd_en_o) begin
                last_cmd_write = (cmd_o == MEM_WRITE);
            end

            if (store_wr_en_o) begin
                if (store_full_i) begin
                    report_error("store push while the queue is full");
                end
                if (exp_store.size() == 0) begin
                    report_error("store push with no read data pending");
                end else begin
                    exp_word = exp_store.pop_front();
                    if (store_data_o != exp_word) begin
                        report_error($sformatf("store data %0h, expected %0h",
                                               store_data_o, exp_word));
                    end
                end
                push_cnt++;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        init_done_i  = 1'b0;
        store_full_i = 1'b0;
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            buf_st[i] = BUF_AVAILABLE;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        while (dn_frames < RUN_FRAMES && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        timed_out = (dn_frames < RUN_FRAMES);
        if (timed_out) begin
            $display("timeout: %0d of %0d download frames done after %0d cycles",
                     dn_frames, RUN_FRAMES, cycle_cnt);
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/vidctl_pkg.sv
logic/buffer_table.sv
logic/frame_session.sv
logic/frame_writer.sv
logic/frame_reader.sv
logic/mem_port_arbiter.sv
logic/video_controller.sv
tb/frame_memory_model.sv
tb/video_controller_tb.sv
